// ==== flist.f ====
logic/decodePkg.sv
logic/instFields.sv
logic/uopClassifier.sv
logic/mduSplitter.sv
logic/uopAssemble.sv
logic/decodeStage.sv
testbench/decodeTb.sv

// ==== run.sh ====
#!/bin/sh
# compile with Verilator and run; the exit status is the test result
cd "$(dirname "$0")" \
    && verilator --binary --timing -f flist.f --top-module decodeTb -o decodeSim \
    && ./obj_dir/decodeSim \
    || { echo "simulation failed"; exit 1; }

// ==== testbench/decodeTb.sv ====
`timescale 1ns/1ps

module decodeTb
    import decodePkg::*;
();
    logic        clk;
    logic        rstN;
    instBundle_t inst;
    uop_t        uop0;
    uop_t        uop1;
    uop_t        exp0;   // expected for the bundle in the output register
    uop_t        exp1;

    logic [5:0] rFunct [0:9] = '{6'h20, 6'h21, 6'h22, 6'h23, 6'h2a, 6'h2b,
                                 6'h24, 6'h25, 6'h26, 6'h27};
    uopKind_e   rKind [0:9] = '{addU, adduU, subU, subuU, sltU, sltuU, andU, orU, xorU, norU};
    uopKind_e   iKind [0:6] = '{addiU, addiuU, sltiU, sltiuU, andiU, oriU, xoriU};
    logic [5:0] shFunct [0:5] = '{6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07};
    uopKind_e   shKind [0:5] = '{sllU, srlU, sraU, sllvU, srlvU, sravU};
    logic [5:0] brOpc [0:3] = '{6'h06, 6'h07, 6'h01, 6'h01};
    logic [4:0] brRt [0:3] = '{5'h00, 5'h00, 5'h00, 5'h01};
    uopKind_e   brKind [0:3] = '{blezU, bgtzU, bltzU, bgezU};
    uopKind_e   mdHi [0:3] = '{multHi, multuHi, divHi, divuHi};
    uopKind_e   mdLo [0:3] = '{multLo, multuLo, divLo, divuLo};
    logic [5:0] ldOpc [0:4] = '{6'h20, 6'h21, 6'h23, 6'h24, 6'h25};
    uopKind_e   ldKind [0:4] = '{lbU, lhU, lwU, lbuU, lhuU};
    logic [5:0] stOpc [0:2] = '{6'h28, 6'h29, 6'h2b};
    uopKind_e   stKind [0:2] = '{sbU, shU, swU};
    logic [5:0] resOpc [0:5] = '{6'h10, 6'h11, 6'h12, 6'h3f, 6'h2a, 6'h2e};   // cp0, swl, swr

    decodeStage UUT (
        .clk  (clk),
        .rstN (rstN),
        .inst (inst),
        .uop0 (uop0),
        .uop1 (uop1)
    );

    always #10 clk = ~clk;

    initial begin
        #40000;
        $display("ERRORS FOUND");
        $fatal(1, "simulation did not finish in time, the clock may have stopped");
    end

    function automatic uop_t setBody(uop_t u, uopKind_e k, unit_e un, aluType_e a,
                                     regAddr_t a0, regAddr_t a1, regAddr_t ad,
                                     logic r0, logic r1, logic we);
        uop_t r;
        r         = u;
        r.kind    = k;
        r.unit    = un;
        r.aluType = a;
        r.op0Addr = a0;
        r.op1Addr = a1;
        r.dstAddr = ad;
        r.op0re   = r0;
        r.op1re   = r1;
        r.dstwe   = we;
        return r;
    endfunction

    function automatic string diffField(uop_t g, uop_t e);
        if (g.valid !== e.valid) return "valid";
        if (g.kind !== e.kind) return "kind";
        if (g.unit !== e.unit) return "unit";
        if (g.aluType !== e.aluType) return "aluType";
        if (g.op0Addr !== e.op0Addr) return "op0Addr";
        if (g.op1Addr !== e.op1Addr) return "op1Addr";
        if (g.dstAddr !== e.dstAddr) return "dstAddr";
        if (g.op0re !== e.op0re) return "op0re";
        if (g.op1re !== e.op1re) return "op1re";
        if (g.dstwe !== e.dstwe) return "dstwe";
        if (g.imm !== e.imm) return "imm";
        if (g.branchType !== e.branchType) return "branchType";
        if (g.branchAddr !== e.branchAddr) return "branchAddr";
        if (g.pc !== e.pc) return "pc";
        if (g.causeExc !== e.causeExc) return "causeExc";
        if (g.exception !== e.exception) return "exception";
        if (g.badVAddr !== e.badVAddr) return "badVAddr";
        return "unknown";
    endfunction

    task automatic failUop(string which, uop_t got, uop_t want);
        $display("[ERROR] %0t %s field %s got %h expected %h",
                 $time, which, diffField(got, want), got, want);
        $display("ERRORS FOUND");
        $fatal(1, "decode output mismatch");
    endtask

    task automatic checkOutputs;
        assert (uop0 === exp0) else failUop("uop0", uop0, exp0);
        assert (uop1 === exp1) else failUop("uop1", uop1, exp1);
    endtask

    task automatic waitFall;
        logic seen;
        int   n;
        seen = 1'b0;
        n    = 0;
        while (!seen) begin
            @(clk);
            n++;
            seen = (clk == 1'b0);
            if (!seen && n > 2) begin
                $display("ERRORS FOUND");
                $fatal(1, "no falling clock edge seen");
            end
        end
    endtask

    // encode instruction number op and derive its micro-op pair from the ISA rules
    task automatic makeCase(input int op, input word_t pc, output word_t w,
                            output uop_t e0, output uop_t e1);
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sa;
        logic [15:0] im;
        logic [25:0] idx;
        regAddr_t    xs;
        regAddr_t    xt;
        regAddr_t    xd;
        immSel_e     isel;
        excCode_e    exc;
        int          k;
        rs   = 5'($urandom);
        rt   = 5'($urandom);
        rd   = 5'($urandom % 31 + 1);   // never zero, keeps sll off the nop word
        sa   = 5'($urandom);
        im   = 16'($urandom);
        idx  = 26'($urandom);
        xs   = {1'b0, rs};
        xt   = {1'b0, rt};
        xd   = {1'b0, rd};
        isel = immSigned;
        exc  = excNone;
        w    = '0;
        e0   = '0;
        e1   = '0;
        if (op == 0) begin
            e0 = setBody(e0, nopU, unitAlu, aluMisc, 6'd0, 6'd0, 6'd0, 1'b0, 1'b0, 1'b0);
        end else if (op <= 10) begin
            k  = op - 1;
            w  = {6'h00, rs, rt, rd, 5'h00, rFunct[k]};
            e0 = setBody(e0, rKind[k], unitAlu, (k < 6) ? aluArith : aluLogic,
                         xs, xt, xd, 1'b1, 1'b1, 1'b1);
        end else if (op <= 17) begin
            k    = op - 11;
            w    = {6'(k + 8), rs, rt, im};
            isel = (k < 4) ? immSigned : immZero;
            e0   = setBody(e0, iKind[k], unitAlu, (k < 4) ? aluArith : aluLogic,
                           xs, 6'd0, xt, 1'b1, 1'b0, 1'b1);
        end else if (op == 18) begin
            w    = {6'h0f, 5'h00, rt, im};
            isel = immUpper;
            e0   = setBody(e0, luiU, unitAlu, aluLogic, 6'd0, 6'd0, xt, 1'b0, 1'b0, 1'b1);
        end else if (op <= 24) begin
            k    = op - 19;
            isel = immShamt;
            if (k < 3) begin
                w  = {11'h000, rt, rd, sa, shFunct[k]};
                e0 = setBody(e0, shKind[k], unitAlu, aluShift, xt, 6'd0, xd, 1'b1, 1'b0, 1'b1);
            end else begin
                w  = {6'h00, rs, rt, rd, 5'h00, shFunct[k]};
                e0 = setBody(e0, shKind[k], unitAlu, aluShift, xt, xs, xd, 1'b1, 1'b1, 1'b1);
            end
        end else if (op <= 32) begin
            e0.branchType = brCond;
            e0.branchAddr = pc + {{14{im[15]}}, im, 2'b00};
            if (op <= 26) begin
                w  = {(op == 25) ? 6'h04 : 6'h05, rs, rt, im};
                e0 = setBody(e0, (op == 25) ? beqU : bneU, unitAlu, aluBranch,
                             xs, xt, 6'd0, 1'b1, 1'b1, 1'b0);
            end else if (op <= 30) begin
                k  = op - 27;
                w  = {brOpc[k], rs, brRt[k], im};
                e0 = setBody(e0, brKind[k], unitAlu, aluBranch, xs, 6'd0, 6'd0,
                             1'b1, 1'b0, 1'b0);
            end else begin
                w  = {6'h01, rs, (op == 31) ? 5'h10 : 5'h11, im};
                e0 = setBody(e0, (op == 31) ? bltzalU : bgezalU, unitAlu, aluBranch,
                             xs, 6'd0, 6'd31, 1'b1, 1'b0, 1'b1);
            end
        end else if (op <= 34) begin
            w             = {(op == 33) ? 6'h02 : 6'h03, idx};
            e0.branchType = brJump;
            e0.branchAddr = {pc[31:28], idx, 2'b00};
            e0 = setBody(e0, (op == 33) ? jU : jalU, unitAlu, aluBranch, 6'd0, 6'd0,
                         (op == 34) ? 6'd31 : 6'd0, 1'b0, 1'b0, (op == 34));
        end else if (op <= 36) begin
            w             = {6'h00, rs, 5'h00, (op == 36) ? rd : 5'h00, 5'h00, 6'(op - 27)};
            e0.branchType = brReg;
            e0 = setBody(e0, (op == 35) ? jrU : jalrU, unitAlu, aluBranch, xs, 6'd0,
                         (op == 36) ? xd : 6'd0, 1'b1, 1'b0, (op == 36));
        end else if (op <= 38) begin
            w  = {16'h0000, rd, 5'h00, (op == 37) ? 6'h10 : 6'h12};
            e0 = setBody(e0, (op == 37) ? mfhiU : mfloU, unitAlu, aluMove,
                         (op == 37) ? regHi : regLo, 6'd0, xd, 1'b1, 1'b0, 1'b1);
        end else if (op <= 40) begin
            w  = {6'h00, rs, 15'h0000, (op == 39) ? 6'h11 : 6'h13};
            e0 = setBody(e0, (op == 39) ? mthiU : mtloU, unitAlu, aluMove, xs, 6'd0,
                         (op == 39) ? regHi : regLo, 1'b1, 1'b0, 1'b1);
        end else if (op <= 44) begin
            k  = op - 41;
            w  = {6'h00, rs, rt, 10'h000, 6'(k + 24)};
            e0 = setBody(e0, mdHi[k], unitMdu, aluArith, xs, xt, regHi, 1'b1, 1'b1, 1'b1);
            e1 = setBody(e1, mdLo[k], unitMdu, aluArith, xs, xt, regLo, 1'b1, 1'b1, 1'b1);
        end else if (op == 45) begin
            w  = {6'h1c, rs, rt, rd, 5'h00, 6'h02};   // mul keeps only the low word
            e0 = setBody(e0, multHi, unitMdu, aluArith, xs, xt, 6'd0, 1'b1, 1'b1, 1'b0);
            e1 = setBody(e1, multLo, unitMdu, aluArith, xs, xt, xd, 1'b1, 1'b1, 1'b1);
        end else if (op <= 50) begin
            k  = op - 46;
            w  = {ldOpc[k], rs, rt, im};
            e0 = setBody(e0, ldKind[k], unitLsu, aluArith, xs, 6'd0, xt, 1'b1, 1'b0, 1'b1);
        end else if (op <= 53) begin
            k  = op - 51;
            w  = {stOpc[k], rs, rt, im};
            e0 = setBody(e0, stKind[k], unitLsu, aluArith, xs, xt, 6'd0, 1'b1, 1'b1, 1'b0);
        end else if (op <= 55) begin
            w   = {6'h00, 20'($urandom), (op == 54) ? 6'h0c : 6'h0d};
            exc = (op == 54) ? excSysCall : excBreak;
            e0  = setBody(e0, (op == 54) ? syscallU : breakU, unitAlu, aluMisc,
                          6'd0, 6'd0, 6'd0, 1'b0, 1'b0, 1'b0);
        end else begin
            w   = {resOpc[$urandom % 6], 26'($urandom)};
            exc = excReserved;
            e0  = setBody(e0, reservedU, unitAlu, aluMisc, 6'd0, 6'd0, 6'd0, 1'b0, 1'b0, 1'b0);
        end
        case (isel)
            immZero:  e0.imm = {16'h0000, w[15:0]};
            immShamt: e0.imm = {27'h0, w[10:6]};
            immUpper: e0.imm = {w[15:0], 16'h0000};
            default:  e0.imm = {{16{w[15]}}, w[15:0]};
        endcase
        e0.pc        = pc;
        e1.pc        = pc;
        e0.exception = exc;
        e0.causeExc  = (exc != excNone);
    endtask

    task automatic applyBundle(input int op, input logic v, input logic bad);
        word_t pc;
        word_t pred;
        word_t w;
        uop_t  e0;
        uop_t  e1;
        pc   = $urandom;
        pred = $urandom;
        makeCase(op, pc, w, e0, e1);
        e0.valid = v && ((op != 0) || bad);
        e1.valid = v && (e1.unit == unitMdu);
        if (bad) begin   // fetch error has top priority
            e0.causeExc  = 1'b1;
            e0.exception = excFetchAddr;
            e0.badVAddr  = pred;
        end
        inst.valid    = v;
        inst.pc       = pc;
        inst.inst     = w;
        inst.jBadAddr = bad;
        inst.predAddr = pred;
        exp0          = e0;
        exp1          = e1;
    endtask

    initial begin
        word_t w;
        int    op;
        logic  v;
        logic  bad;
        void'($urandom(32'hfa28_94f8));
        clk  = 1'b0;
        rstN = 1'b0;
        inst = '0;
        exp0 = '0;
        exp1 = '0;
        for (int i = 0; i < 16; i++) begin
            waitFall;
            checkOutputs;
            applyBundle(41 + i % 5, 1'b1, (i % 4 == 3));   // valid mdu bundles under reset
            exp0 = '0;
            exp1 = '0;
        end
        inst = '0;
        rstN = 1'b1;
        makeCase(0, 32'h0, w, exp0, exp1);   // idle bundle at the first edge after reset
        for (int i = 0; i < 900; i++) begin
            if (i < 57) begin
                op = i;   // sweep every instruction once
            end else if (i == 57) begin
                op = 0;
            end else begin
                op = int'($urandom % 57);
            end
            v   = (i <= 57) || ($urandom % 8 != 0);
            bad = (i == 57) || ((i > 57) && ($urandom % 10 == 0));
            waitFall;
            checkOutputs;
            applyBundle(op, v, bad);
        end
        waitFall;
        checkOutputs;
        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== logic/decodeStage.sv ====
`timescale 1ns/1ps

module decodeStage
    import decodePkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  instBundle_t inst,
    output uop_t        uop0,
    output uop_t        uop1
);
    instFields_t  fields;
    uopTemplate_t tmpl;
    mduPair_t     mduPair;

    instFields fieldSplit (
        .inst   (inst),
        .fields (fields)
    );

    uopClassifier classifier (
        .instWord (inst.inst),
        .tmpl     (tmpl)
    );

    mduSplitter splitter (
        .tmpl     (tmpl),
        .instWord (inst.inst),
        .fields   (fields),
        .mduPair  (mduPair)
    );

    uopAssemble assembler (   // only registered stage
        .clk     (clk),
        .rstN    (rstN),
        .inst    (inst),
        .fields  (fields),
        .tmpl    (tmpl),
        .mduPair (mduPair),
        .uop0    (uop0),
        .uop1    (uop1)
    );

endmodule

// ==== logic/uopAssemble.sv ====
`timescale 1ns/1ps

module uopAssemble
    import decodePkg::*;
(
    input  logic         clk,
    input  logic         rstN,
    input  instBundle_t  inst,
    input  instFields_t  fields,
    input  uopTemplate_t tmpl,
    input  mduPair_t     mduPair,
    output uop_t         uop0,
    output uop_t         uop1
);
    uopBody_t tmplBody;
    uop_t     nxt0;
    uop_t     nxt1;

    function automatic regAddr_t pick(opSel_e s, instFields_t f);
        case (s)
            selRs:   return f.rs;
            selRt:   return f.rt;
            selRd:   return f.rd;
            selHi:   return regHi;
            selLo:   return regLo;
            selLink: return regLink;
            default: return '0;
        endcase
    endfunction

    function automatic uop_t withBody(uop_t u, uopBody_t b);
        uop_t r;
        r         = u;
        r.kind    = b.kind;
        r.unit    = b.unit;
        r.aluType = b.aluType;
        r.op0Addr = b.op0Addr;
        r.op1Addr = b.op1Addr;
        r.dstAddr = b.dstAddr;
        r.op0re   = b.op0re;
        r.op1re   = b.op1re;
        r.dstwe   = b.dstwe;
        return r;
    endfunction

    always_comb begin
        tmplBody.kind    = tmpl.kind;
        tmplBody.unit    = tmpl.unit;
        tmplBody.aluType = tmpl.aluType;
        tmplBody.op0Addr = pick(tmpl.op0Sel, fields);
        tmplBody.op1Addr = pick(tmpl.op1Sel, fields);
        tmplBody.dstAddr = pick(tmpl.dstSel, fields);
        tmplBody.op0re   = tmpl.op0re;
        tmplBody.op1re   = tmpl.op1re;
        tmplBody.dstwe   = tmpl.dstwe;
    end

    always_comb begin
        nxt0 = '0;
        nxt1 = '0;
        nxt0 = withBody(nxt0, tmpl.isMdu ? mduPair[0] : tmplBody);
        if (tmpl.isMdu) begin
            nxt1 = withBody(nxt1, mduPair[1]);
        end
        case (tmpl.immSel)
            immZero:  nxt0.imm = fields.immZero;
            immShamt: nxt0.imm = fields.immShamt;
            immUpper: nxt0.imm = fields.immUpper;
            default:  nxt0.imm = fields.immSigned;
        endcase
        nxt0.branchType = tmpl.branchType;
        case (tmpl.branchType)
            brCond:  nxt0.branchAddr = fields.brTarget;
            brJump:  nxt0.branchAddr = fields.jTarget;
            default: nxt0.branchAddr = '0;   // jr target comes from rs
        endcase
        nxt0.pc        = inst.pc;
        nxt1.pc        = inst.pc;
        nxt0.causeExc  = (tmpl.exception != excNone);
        nxt0.exception = tmpl.exception;
        nxt0.valid     = inst.valid && (!tmpl.isNop || inst.jBadAddr);
        nxt1.valid     = inst.valid && tmpl.isMdu;
        if (inst.jBadAddr) begin   // fetch error beats any decode exception
            nxt0.causeExc  = 1'b1;
            nxt0.exception = excFetchAddr;
            nxt0.badVAddr  = inst.predAddr;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            uop0 <= '0;
            uop1 <= '0;
        end else begin
            uop0 <= nxt0;
            uop1 <= nxt1;
        end
    end

endmodule

// ==== logic/mduSplitter.sv ====
`timescale 1ns/1ps

module mduSplitter
    import decodePkg::*;
(
    input  uopTemplate_t tmpl,
    input  word_t        instWord,
    input  instFields_t  fields,
    output mduPair_t     mduPair
);
    logic     isMul;
    uopKind_e loKind;

    assign isMul = (instWord[31:26] == 6'b011100);   // special2 opcode

    always_comb begin
        case (tmpl.kind)
            multuHi: loKind = multuLo;
            divHi:   loKind = divLo;
            divuHi:  loKind = divuLo;
            default: loKind = multLo;
        endcase
    end

    always_comb begin
        mduPair = '0;
        for (int i = 0; i < 2; i++) begin
            mduPair[i].unit    = unitMdu;
            mduPair[i].aluType = tmpl.aluType;
            mduPair[i].op0Addr = fields.rs;
            mduPair[i].op1Addr = fields.rt;
            mduPair[i].op0re   = tmpl.op0re;
            mduPair[i].op1re   = tmpl.op1re;
        end
        mduPair[0].kind    = tmpl.kind;
        mduPair[0].dstAddr = isMul ? regAddr_t'(0) : regHi;   // mul drops the high word
        mduPair[0].dstwe   = !isMul;
        mduPair[1].kind    = loKind;
        mduPair[1].dstAddr = isMul ? fields.rd : regLo;
        mduPair[1].dstwe   = 1'b1;
    end

endmodule

// ==== logic/uopClassifier.sv ====
`timescale 1ns/1ps

module uopClassifier
    import decodePkg::*;
(
    input  word_t        instWord,
    output uopTemplate_t tmpl
);

    function automatic uopTemplate_t base(uopKind_e k, unit_e u, aluType_e a, opSel_e s0,
                                          opSel_e s1, opSel_e sd, immSel_e i, branchType_e b);
        uopTemplate_t t;
        t            = '0;
        t.kind       = k;
        t.unit       = u;
        t.aluType    = a;
        t.op0Sel     = s0;
        t.op1Sel     = s1;
        t.dstSel     = sd;
        t.op0re      = (s0 != selNone);
        t.op1re      = (s1 != selNone);
        t.dstwe      = (sd != selNone);
        t.immSel     = i;
        t.branchType = b;
        t.isMdu      = (u == unitMdu);
        t.isNop      = (k == nopU);
        t.exception  = excNone;
        return t;
    endfunction

    function automatic uopTemplate_t aluR(uopKind_e k, aluType_e a);
        return base(k, unitAlu, a, selRs, selRt, selRd, immSigned, brNone);
    endfunction

    function automatic uopTemplate_t aluI(uopKind_e k, aluType_e a, immSel_e i);
        return base(k, unitAlu, a, selRs, selNone, selRt, i, brNone);
    endfunction

    function automatic uopTemplate_t shf(uopKind_e k, opSel_e s1);
        return base(k, unitAlu, aluShift, selRt, s1, selRd, immShamt, brNone);
    endfunction

    function automatic uopTemplate_t brc(uopKind_e k, opSel_e s1, opSel_e sd);
        return base(k, unitAlu, aluBranch, selRs, s1, sd, immSigned, brCond);
    endfunction

    function automatic uopTemplate_t jmp(uopKind_e k, opSel_e s0, opSel_e sd, branchType_e b);
        return base(k, unitAlu, aluBranch, s0, selNone, sd, immSigned, b);
    endfunction

    function automatic uopTemplate_t move(uopKind_e k, opSel_e s0, opSel_e sd);
        return base(k, unitAlu, aluMove, s0, selNone, sd, immSigned, brNone);
    endfunction

    function automatic uopTemplate_t mdu(uopKind_e k);
        return base(k, unitMdu, aluArith, selRs, selRt, selHi, immSigned, brNone);
    endfunction

    function automatic uopTemplate_t lsu(uopKind_e k, opSel_e s1, opSel_e sd);
        return base(k, unitLsu, aluArith, selRs, s1, sd, immSigned, brNone);
    endfunction

    function automatic uopTemplate_t misc(uopKind_e k, excCode_e e);
        uopTemplate_t t;
        t           = base(k, unitAlu, aluMisc, selNone, selNone, selNone, immSigned, brNone);
        t.exception = e;
        return t;
    endfunction

    always_comb begin
        priority casez (instWord)
            32'h0000_0000: tmpl = misc(nopU, excNone);   // must win over sll
            32'b000000_?????_?????_?????_00000_100000: tmpl = aluR(addU, aluArith);
            32'b000000_?????_?????_?????_00000_100001: tmpl = aluR(adduU, aluArith);
            32'b000000_?????_?????_?????_00000_100010: tmpl = aluR(subU, aluArith);
            32'b000000_?????_?????_?????_00000_100011: tmpl = aluR(subuU, aluArith);
            32'b000000_?????_?????_?????_00000_101010: tmpl = aluR(sltU, aluArith);
            32'b000000_?????_?????_?????_00000_101011: tmpl = aluR(sltuU, aluArith);
            32'b000000_?????_?????_?????_00000_100100: tmpl = aluR(andU, aluLogic);
            32'b000000_?????_?????_?????_00000_100101: tmpl = aluR(orU, aluLogic);
            32'b000000_?????_?????_?????_00000_100110: tmpl = aluR(xorU, aluLogic);
            32'b000000_?????_?????_?????_00000_100111: tmpl = aluR(norU, aluLogic);
            32'b001000_?????_?????_????????????????: tmpl = aluI(addiU, aluArith, immSigned);
            32'b001001_?????_?????_????????????????: tmpl = aluI(addiuU, aluArith, immSigned);
            32'b001010_?????_?????_????????????????: tmpl = aluI(sltiU, aluArith, immSigned);
            32'b001011_?????_?????_????????????????: tmpl = aluI(sltiuU, aluArith, immSigned);
            32'b001100_?????_?????_????????????????: tmpl = aluI(andiU, aluLogic, immZero);
            32'b001101_?????_?????_????????????????: tmpl = aluI(oriU, aluLogic, immZero);
            32'b001110_?????_?????_????????????????: tmpl = aluI(xoriU, aluLogic, immZero);
            32'b001111_00000_?????_????????????????:
                tmpl = base(luiU, unitAlu, aluLogic, selNone, selNone, selRt, immUpper, brNone);
            32'b000000_00000_?????_?????_?????_000000: tmpl = shf(sllU, selNone);
            32'b000000_00000_?????_?????_?????_000010: tmpl = shf(srlU, selNone);
            32'b000000_00000_?????_?????_?????_000011: tmpl = shf(sraU, selNone);
            32'b000000_?????_?????_?????_00000_000100: tmpl = shf(sllvU, selRs);
            32'b000000_?????_?????_?????_00000_000110: tmpl = shf(srlvU, selRs);
            32'b000000_?????_?????_?????_00000_000111: tmpl = shf(sravU, selRs);
            32'b000100_?????_?????_????????????????: tmpl = brc(beqU, selRt, selNone);
            32'b000101_?????_?????_????????????????: tmpl = brc(bneU, selRt, selNone);
            32'b000110_?????_00000_????????????????: tmpl = brc(blezU, selNone, selNone);
            32'b000111_?????_00000_????????????????: tmpl = brc(bgtzU, selNone, selNone);
            32'b000001_?????_00000_????????????????: tmpl = brc(bltzU, selNone, selNone);
            32'b000001_?????_00001_????????????????: tmpl = brc(bgezU, selNone, selNone);
            32'b000001_?????_10000_????????????????: tmpl = brc(bltzalU, selNone, selLink);
            32'b000001_?????_10001_????????????????: tmpl = brc(bgezalU, selNone, selLink);
            32'b000010_??????????????????????????: tmpl = jmp(jU, selNone, selNone, brJump);
            32'b000011_??????????????????????????: tmpl = jmp(jalU, selNone, selLink, brJump);
            32'b000000_?????_00000_00000_00000_001000: tmpl = jmp(jrU, selRs, selNone, brReg);
            32'b000000_?????_00000_?????_00000_001001: tmpl = jmp(jalrU, selRs, selRd, brReg);
            32'b000000_00000_00000_?????_00000_010000: tmpl = move(mfhiU, selHi, selRd);
            32'b000000_00000_00000_?????_00000_010010: tmpl = move(mfloU, selLo, selRd);
            32'b000000_?????_00000_00000_00000_010001: tmpl = move(mthiU, selRs, selHi);
            32'b000000_?????_00000_00000_00000_010011: tmpl = move(mtloU, selRs, selLo);
            32'b000000_?????_?????_00000_00000_011000: tmpl = mdu(multHi);
            32'b000000_?????_?????_00000_00000_011001: tmpl = mdu(multuHi);
            32'b000000_?????_?????_00000_00000_011010: tmpl = mdu(divHi);
            32'b000000_?????_?????_00000_00000_011011: tmpl = mdu(divuHi);
            32'b011100_?????_?????_?????_00000_000010: tmpl = mdu(multHi);   // mul, lo to rd
            32'b100000_?????_?????_????????????????: tmpl = lsu(lbU, selNone, selRt);
            32'b100001_?????_?????_????????????????: tmpl = lsu(lhU, selNone, selRt);
            32'b100011_?????_?????_????????????????: tmpl = lsu(lwU, selNone, selRt);
            32'b100100_?????_?????_????????????????: tmpl = lsu(lbuU, selNone, selRt);
            32'b100101_?????_?????_????????????????: tmpl = lsu(lhuU, selNone, selRt);
            32'b101000_?????_?????_????????????????: tmpl = lsu(sbU, selRt, selNone);
            32'b101001_?????_?????_????????????????: tmpl = lsu(shU, selRt, selNone);
            32'b101011_?????_?????_????????????????: tmpl = lsu(swU, selRt, selNone);
            32'b000000_????????????????????_001100: tmpl = misc(syscallU, excSysCall);
            32'b000000_????????????????????_001101: tmpl = misc(breakU, excBreak);
            default: tmpl = misc(reservedU, excReserved);   // incl. cp0 and privileged ops
        endcase
    end

endmodule

// ==== logic/instFields.sv ====
`timescale 1ns/1ps

module instFields
    import decodePkg::*;
(
    input  instBundle_t inst,
    output instFields_t fields
);
    word_t w;
    word_t brOffset;

    assign w = inst.inst;

    always_comb begin
        fields.rs        = {1'b0, w[25:21]};
        fields.rt        = {1'b0, w[20:16]};
        fields.rd        = {1'b0, w[15:11]};
        fields.immSigned = {{16{w[15]}}, w[15:0]};
        fields.immZero   = {16'h0000, w[15:0]};
        fields.immShamt  = {27'h0, w[10:6]};
        fields.immUpper  = {w[15:0], 16'h0000};
        fields.brTarget  = inst.pc + brOffset;
        fields.jTarget   = {inst.pc[31:28], w[25:0], 2'b00};   // 256MB region of pc
    end

    assign brOffset = {{14{w[15]}}, w[15:0], 2'b00};   // word offset

endmodule

// ==== logic/decodePkg.sv ====
package decodePkg;

    typedef logic [31:0] word_t;
    typedef logic [5:0]  regAddr_t;   // 0..31 gpr, 32 hi, 33 lo

    localparam regAddr_t regHi   = 6'd32;
    localparam regAddr_t regLo   = 6'd33;
    localparam regAddr_t regLink = 6'd31;

    typedef enum logic [6:0] {
        nopU, reservedU,
        addU, adduU, addiU, addiuU, subU, subuU, sltU, sltuU, sltiU, sltiuU,
        andU, andiU, orU, oriU, xorU, xoriU, norU, luiU,
        sllU, sllvU, sraU, sravU, srlU, srlvU,
        beqU, bneU, bgezU, bgtzU, blezU, bltzU, bgezalU, bltzalU,
        jU, jalU, jrU, jalrU,
        mfhiU, mfloU, mthiU, mtloU,
        multHi, multLo, multuHi, multuLo, divHi, divLo, divuHi, divuLo,
        lbU, lhU, lbuU, lhuU, lwU, sbU, shU, swU,
        syscallU, breakU
    } uopKind_e;

    typedef enum logic [1:0] {unitAlu, unitMdu, unitLsu} unit_e;

    typedef enum logic [2:0] {
        aluArith, aluLogic, aluShift, aluBranch, aluMove, aluMisc
    } aluType_e;

    typedef enum logic [1:0] {brNone, brCond, brJump, brReg} branchType_e;

    typedef enum logic [2:0] {
        excNone, excSysCall, excBreak, excReserved, excFetchAddr
    } excCode_e;

    typedef enum logic [2:0] {
        selNone, selRs, selRt, selRd, selHi, selLo, selLink
    } opSel_e;

    typedef enum logic [1:0] {immSigned, immZero, immShamt, immUpper} immSel_e;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t inst;
        logic  jBadAddr;
        word_t predAddr;   // only reported as bad address
    } instBundle_t;

    typedef struct packed {
        logic        valid;
        uopKind_e    kind;
        unit_e       unit;
        aluType_e    aluType;
        regAddr_t    op0Addr;
        regAddr_t    op1Addr;
        regAddr_t    dstAddr;
        logic        op0re;
        logic        op1re;
        logic        dstwe;
        word_t       imm;
        branchType_e branchType;
        word_t       branchAddr;
        word_t       pc;
        logic        causeExc;
        excCode_e    exception;
        word_t       badVAddr;
    } uop_t;

    // operand part of a micro-op, shared by the template path and the mdu pair
    typedef struct packed {
        uopKind_e kind;
        unit_e    unit;
        aluType_e aluType;
        regAddr_t op0Addr;
        regAddr_t op1Addr;
        regAddr_t dstAddr;
        logic     op0re;
        logic     op1re;
        logic     dstwe;
    } uopBody_t;

    typedef uopBody_t [1:0] mduPair_t;   // [0] hi, [1] lo

    typedef struct packed {
        regAddr_t rs;
        regAddr_t rt;
        regAddr_t rd;
        word_t    immSigned;
        word_t    immZero;
        word_t    immShamt;
        word_t    immUpper;
        word_t    brTarget;
        word_t    jTarget;
    } instFields_t;

    typedef struct packed {
        uopKind_e    kind;
        unit_e       unit;
        aluType_e    aluType;
        opSel_e      op0Sel;
        opSel_e      op1Sel;
        opSel_e      dstSel;
        logic        op0re;
        logic        op1re;
        logic        dstwe;
        immSel_e     immSel;
        branchType_e branchType;
        logic        isMdu;
        logic        isNop;
        excCode_e    exception;
    } uopTemplate_t;

endpackage
